// ==== run_sim.sh ====
#!/bin/sh
# Build the PCS transmit testbench with Verilator, run it and scan the log.

top=tb_baser_tx
build_dir=obj_dir
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module "$top" \
    -Mdir "$build_dir" \
    -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$log"; then
    echo "simulation reported failure, see $log"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== sim/baser_tx_checker.sv ====
// TX block checker: descrambles the line output and compares each block with the expected one
`timescale 1ns/1ps

module baser_tx_checker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [baser_pkg::blk_data_w-1:0] tx_data,
    input  logic [1:0]                       tx_hdr,
    input  logic                             exp_valid,
    input  logic [1:0]                       exp_hdr,
    input  logic [baser_pkg::blk_data_w-1:0] exp_data,
    input  logic                             bypass,
    output int                               err_cnt,
    output int                               chk_cnt
);
    import baser_pkg::*;

    logic [scr_state_w-1:0] dscr_state;
    logic [blk_data_w-1:0]  plain;
    logic                   live;       // last rising edge was out of reset
    int                     cyc = 0;
    int                     errs = 0;
    int                     checks = 0;

    // expected blocks in flight, tagged with the cycle they show up on tx_data
    logic [1:0]            q_hdr[$];
    logic [blk_data_w-1:0] q_data[$];
    logic                  q_bypass[$];
    int                    q_due[$];

    assign err_cnt = errs;
    assign chk_cnt = checks;

    always begin
        logic [scr_state_w-1:0] st;
        logic [blk_data_w-1:0]  got;
        @(posedge clk);
        live = rst_n;
        cyc  = cyc + 1;
        if (rst_n && exp_valid) begin
            q_hdr.push_back(exp_hdr);
            q_data.push_back(exp_data);
            q_bypass.push_back(bypass);
            q_due.push_back(cyc + 1);  // encoder plus scrambler
        end

        @(negedge clk);
        if (live !== 1'b1) begin
            dscr_state = '1;  // transmitter starts from all ones too
        end else begin
            // x^58 + x^39 + 1, received bit shifts into the state
            st = dscr_state;
            for (int i = 0; i < blk_data_w; i++) begin
                plain[i] = tx_data[i] ^ st[38] ^ st[57];
                st       = {st[scr_state_w-2:0], tx_data[i]};
            end
            dscr_state = st;

            if (q_due.size() > 0 && q_due[0] == cyc) begin
                got = q_bypass[0] ? tx_data : plain;
                if (tx_hdr !== q_hdr[0]) begin
                    $display("ERR %0t tx_hdr: got %b, expected %b", $time, tx_hdr, q_hdr[0]);
                    errs++;
                end
                if (got !== q_data[0]) begin
                    $display("ERR %0t tx_data: got %h, expected %h", $time, got, q_data[0]);
                    errs++;
                end
                checks++;
                void'(q_hdr.pop_front());
                void'(q_data.pop_front());
                void'(q_bypass.pop_front());
                void'(q_due.pop_front());
            end
        end
    end

endmodule

// ==== sim/tb_baser_tx.sv ====
// testbench for the 10GBASE-R PCS transmit path, table-driven XGMII stimulus and APB register checks
`timescale 1ns/1ps

module tb_baser_tx;
    import baser_pkg::*;
    import baser_regs_pkg::*;

    localparam int clk_period = 40;
    localparam int apb_xfers  = 10;
    localparam int idle_slack = 40;  // reset, idle gaps and drain

    logic                  clk;
    logic                  rst_n;
    logic [blk_data_w-1:0] xgmii_txd;
    logic [7:0]            xgmii_txc;
    logic [blk_data_w-1:0] tx_data;
    logic [1:0]            tx_hdr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pslverr;

    // expected block handed to the checker with each row
    logic                  exp_valid;
    logic [1:0]            exp_hdr;
    logic [blk_data_w-1:0] exp_data;
    logic                  chk_bypass;
    int                    chk_errs;
    int                    chk_count;

    int reg_errs    = 0;
    int cyc         = 0;
    int last_wr_cyc = 0;
    int rows_sent   = 0;
    int n_bad       = 0;
    bit table_ready = 1'b0;

    // stimulus table: txd, txc, header, unscrambled payload, bad flag
    logic [63:0] tab_txd[$];
    logic [7:0]  tab_txc[$];
    logic [1:0]  tab_hdr[$];
    logic [63:0] tab_data[$];
    logic        tab_bad[$];

    baser_tx_top i_baser_tx_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc),
        .tx_data   (tx_data),
        .tx_hdr    (tx_hdr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr)
    );

    baser_tx_checker i_baser_tx_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_hdr    (tx_hdr),
        .exp_valid (exp_valid),
        .exp_hdr   (exp_hdr),
        .exp_data  (exp_data),
        .bypass    (chk_bypass),
        .err_cnt   (chk_errs),
        .chk_cnt   (chk_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic add_row(input logic [63:0] txd, input logic [7:0] txc,
                           input logic [1:0] hdr, input logic [63:0] data, input logic bad);
        tab_txd.push_back(txd);
        tab_txc.push_back(txc);
        tab_hdr.push_back(hdr);
        tab_data.push_back(data);
        tab_bad.push_back(bad);
    endtask

    task automatic build_table();
        logic [63:0] rnd;
        add_row(64'h0707070707070707, 8'hff, sync_ctrl, 64'h0000_0000_0000_001e, 1'b0);
        add_row(64'h0606060606060606, 8'hff, sync_ctrl, {{8{7'h06}}, 8'h1e}, 1'b0);  // lpi
        add_row(64'hfefefefefefefefe, 8'hff, sync_ctrl, {{8{7'h1e}}, 8'h1e}, 1'b0);
        add_row(64'hd5555555555555fb, 8'h01, sync_ctrl, 64'hd555_5555_5555_5578, 1'b0);
        add_row(64'h0123456789abcdef, 8'h00, sync_data, 64'h0123_4567_89ab_cdef, 1'b0);
        add_row(64'hfd77665544332211, 8'h80, sync_ctrl, 64'h7766_5544_3322_11ff, 1'b0);
        add_row(64'h776655fb07070707, 8'h1f, sync_ctrl, 64'h7766_5500_0000_0033, 1'b0);
        add_row(64'h8899aabbccddeeff, 8'h00, sync_data, 64'h8899_aabb_ccdd_eeff, 1'b0);
        // terminate walking down from lane 6
        add_row(64'h07fd665544332211, 8'hc0, sync_ctrl, 64'h0066_5544_3322_11e1, 1'b0);
        add_row(64'h0707fd5544332211, 8'he0, sync_ctrl, 64'h0000_5544_3322_11d2, 1'b0);
        add_row(64'h070707fd44332211, 8'hf0, sync_ctrl, 64'h0000_0044_3322_11cc, 1'b0);
        add_row(64'h07070707fd332211, 8'hf8, sync_ctrl, 64'h0000_0000_3322_11b4, 1'b0);
        add_row(64'h0707070707fd2211, 8'hfc, sync_ctrl, 64'h0000_0000_0022_11aa, 1'b0);
        add_row(64'h070707070707fd11, 8'hfe, sync_ctrl, 64'h0000_0000_0000_1199, 1'b0);
        add_row(64'h07070707070707fd, 8'hff, sync_ctrl, 64'h0000_0000_0000_0087, 1'b0);
        // ordered sets
        add_row(64'h070707073322119c, 8'hf1, sync_ctrl, 64'h0000_0000_3322_114b, 1'b0);
        add_row(64'h7766559c07070707, 8'h1f, sync_ctrl, 64'h7766_5500_0000_002d, 1'b0);
        add_row(64'h776655fb3322119c, 8'h11, sync_ctrl, 64'h7766_5500_3322_1166, 1'b0);
        add_row(64'h7766559c3322119c, 8'h11, sync_ctrl, 64'h7766_5500_3322_1155, 1'b0);
        // bad blocks
        add_row(64'h0707070707070707, 8'h0f, sync_ctrl, {{8{7'h1e}}, 8'h1e}, 1'b1);
        add_row(64'h07070707070707aa, 8'hff, sync_ctrl, 64'h0000_0000_0000_1e1e, 1'b1);
        add_row(64'h112233445566fb77, 8'h02, sync_ctrl, {{8{7'h1e}}, 8'h1e}, 1'b1);
        add_row(64'hd555555555555507, 8'h01, sync_ctrl, {{8{7'h1e}}, 8'h1e}, 1'b1);
        add_row(64'h000707fd44332211, 8'hf0, sync_ctrl, 64'h3c00_0044_3322_11cc, 1'b1);
        for (int i = 0; i < 8; i++) begin
            rnd = {$urandom(), $urandom()};
            add_row(rnd, 8'h00, sync_data, rnd, 1'b0);
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            xgmii_txd = {8{xgmii_idle}};
            xgmii_txc = 8'hff;
            exp_valid = 1'b0;
        end
    endtask

    task automatic apply_table();
        for (int i = 0; i < tab_txd.size(); i++) begin
            @(negedge clk);
            xgmii_txd = tab_txd[i];
            xgmii_txc = tab_txc[i];
            exp_hdr   = tab_hdr[i];
            exp_data  = tab_data[i];
            exp_valid = 1'b1;
            rows_sent++;
        end
        drive_idle(1);
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] addr,
                             input logic [apb_data_w-1:0] data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        err         = pslverr;  // still in the access phase
        last_wr_cyc = cyc;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [apb_data_w-1:0] data,
                            output logic err, output int setup_cyc);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        setup_cyc = cyc;  // edge where prdata was captured
        penable   = 1'b1;
        @(negedge clk);
        data    = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            reg_errs++;
        end
    endtask

    initial begin
        logic [apb_data_w-1:0] rd;
        logic                  err;
        int                    setup_cyc;
        void'($urandom(32'h3b4703c8));
        rst_n      = 1'b0;
        xgmii_txd  = {8{xgmii_idle}};
        xgmii_txc  = 8'hff;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        exp_valid  = 1'b0;
        exp_hdr    = sync_ctrl;
        exp_data   = '0;
        chk_bypass = 1'b0;
        build_table();
        foreach (tab_bad[i]) n_bad += int'(tab_bad[i]);
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        drive_idle(2);

        apply_table();  // scrambled pass
        drive_idle(2);
        apb_read(reg_bad_cnt, rd, err, setup_cyc);
        expect_val("reg_bad_cnt", rd, n_bad);
        expect_val("pslverr", err, 0);

        // clear both counters, then let the block counter run a while
        apb_write(reg_ctrl, 32'h2, err);
        expect_val("pslverr", err, 0);
        drive_idle(5);
        apb_read(reg_block_cnt, rd, err, setup_cyc);
        expect_val("reg_block_cnt", rd, setup_cyc - last_wr_cyc - 1);
        apb_read(reg_bad_cnt, rd, err, setup_cyc);
        expect_val("reg_bad_cnt", rd, 0);
        apb_read(reg_ctrl, rd, err, setup_cyc);
        expect_val("reg_ctrl", rd, 0);

        // unmapped offsets
        apb_read(8'h0c, rd, err, setup_cyc);
        expect_val("pslverr", err, 1);
        apb_write(8'h20, 32'h1, err);
        expect_val("pslverr", err, 1);
        apb_read(reg_ctrl, rd, err, setup_cyc);
        expect_val("reg_ctrl", rd, 0);

        apb_write(reg_ctrl, 32'h1, err);  // scrambler bypass on
        apb_read(reg_ctrl, rd, err, setup_cyc);
        expect_val("reg_ctrl", rd, 1);
        chk_bypass = 1'b1;
        apply_table();
        drive_idle(4);

        if (chk_count != rows_sent) begin
            $display("checker compared %0d blocks, but %0d rows were sent", chk_count, rows_sent);
            reg_errs++;
        end
        $display("errors: %0d block, %0d register", chk_errs, reg_errs);
        if (chk_errs == 0 && reg_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the table length and the APB traffic
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (2 * tab_txd.size() + 3 * apb_xfers + idle_slack) * clk_period * 2;
        #(limit_ns);
        $display("timeout: simulation still running after %0d ns", limit_ns);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/baser_pkg.sv
verilog/baser_regs_pkg.sv
verilog/xgmii_baser_encoder.sv
verilog/baser_scrambler.sv
verilog/baser_tx_status.sv
verilog/baser_tx_top.sv
sim/baser_tx_checker.sv
sim/tb_baser_tx.sv

// ==== verilog/baser_pkg.sv ====
// 10GBASE-R PCS constants: XGMII characters, line codes, sync headers, block types
package baser_pkg;

    // XGMII control characters
    localparam logic [7:0] xgmii_idle   = 8'h07;
    localparam logic [7:0] xgmii_lpi    = 8'h06;
    localparam logic [7:0] xgmii_start  = 8'hfb;
    localparam logic [7:0] xgmii_term   = 8'hfd;
    localparam logic [7:0] xgmii_error  = 8'hfe;
    localparam logic [7:0] xgmii_seq_os = 8'h9c;
    localparam logic [7:0] xgmii_res_0  = 8'h1c;
    localparam logic [7:0] xgmii_res_1  = 8'h3c;
    localparam logic [7:0] xgmii_res_2  = 8'h7c;
    localparam logic [7:0] xgmii_res_3  = 8'hbc;
    localparam logic [7:0] xgmii_res_4  = 8'hdc;
    localparam logic [7:0] xgmii_res_5  = 8'hf7;

    // 7-bit control codes on the line
    localparam logic [6:0] ctrl_idle  = 7'h00;
    localparam logic [6:0] ctrl_lpi   = 7'h06;
    localparam logic [6:0] ctrl_error = 7'h1e;
    localparam logic [6:0] ctrl_res_0 = 7'h2d;
    localparam logic [6:0] ctrl_res_1 = 7'h33;
    localparam logic [6:0] ctrl_res_2 = 7'h4b;
    localparam logic [6:0] ctrl_res_3 = 7'h55;
    localparam logic [6:0] ctrl_res_4 = 7'h66;
    localparam logic [6:0] ctrl_res_5 = 7'h78;

    localparam logic [3:0] o_seq_os = 4'h0;  // sequence ordered set

    localparam logic [1:0] sync_data = 2'b10;
    localparam logic [1:0] sync_ctrl = 2'b01;

    // block type field, byte layout from msb to lsb in the comments
    localparam logic [7:0] bt_ctrl     = 8'h1e;  // C7 C6 C5 C4 C3 C2 C1 C0
    localparam logic [7:0] bt_os_4     = 8'h2d;  // D7 D6 D5 O4 C3 C2 C1 C0
    localparam logic [7:0] bt_start_4  = 8'h33;  // D7 D6 D5 -- C3 C2 C1 C0
    localparam logic [7:0] bt_os_start = 8'h66;  // D7 D6 D5 -- O0 D3 D2 D1
    localparam logic [7:0] bt_os_04    = 8'h55;  // D7 D6 D5 O4 O0 D3 D2 D1
    localparam logic [7:0] bt_start_0  = 8'h78;  // D7 D6 D5 D4 D3 D2 D1
    localparam logic [7:0] bt_os_0     = 8'h4b;  // C7 C6 C5 C4 O0 D3 D2 D1
    localparam logic [7:0] bt_term_0   = 8'h87;  // C7 C6 C5 C4 C3 C2 C1
    localparam logic [7:0] bt_term_1   = 8'h99;  // C7 C6 C5 C4 C3 C2 -- D0
    localparam logic [7:0] bt_term_2   = 8'haa;  // C7 C6 C5 C4 C3 -- D1 D0
    localparam logic [7:0] bt_term_3   = 8'hb4;  // C7 C6 C5 C4 -- D2 D1 D0
    localparam logic [7:0] bt_term_4   = 8'hcc;  // C7 C6 C5 -- D3 D2 D1 D0
    localparam logic [7:0] bt_term_5   = 8'hd2;  // C7 C6 -- D4 D3 D2 D1 D0
    localparam logic [7:0] bt_term_6   = 8'he1;  // C7 -- D5 D4 D3 D2 D1 D0
    localparam logic [7:0] bt_term_7   = 8'hff;  // -- D6 D5 D4 D3 D2 D1 D0

    // payload and scrambler sizes
    localparam int blk_data_w  = 64;
    localparam int scr_state_w = 58;

    // x^58 + x^39 + 1, as state bit indices
    localparam int scr_tap_0 = 38;
    localparam int scr_tap_1 = 57;

endpackage

// ==== verilog/baser_regs_pkg.sv ====
// 10GBASE-R TX status block register map and APB sizes
package baser_regs_pkg;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // register offsets
    localparam logic [apb_addr_w-1:0] reg_ctrl      = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_block_cnt = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_bad_cnt   = 8'h08;

    // reg_ctrl fields
    localparam int bit_scr_bypass = 0;
    localparam int bit_cnt_clear  = 1;  // write one, reads back zero

    localparam logic [apb_data_w-1:0] ctrl_reset = 32'h0000_0000;

    // counter widths
    localparam int block_cnt_w = 32;  // wraps
    localparam int bad_cnt_w   = 16;  // saturates

endpackage

// ==== verilog/baser_scrambler.sv ====
// 10GBASE-R payload scrambler, self-synchronizing x^58 + x^39 + 1, 64 bits per cycle
`timescale 1ns/1ps

module baser_scrambler (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           scr_bypass,
    input  logic [baser_pkg::blk_data_w-1:0] enc_data,
    input  logic [1:0]                     enc_hdr,
    output logic [baser_pkg::blk_data_w-1:0] tx_data,
    output logic [1:0]                     tx_hdr
);
    import baser_pkg::*;

    logic [scr_state_w-1:0] scr_state;
    logic [scr_state_w-1:0] state_next;
    logic [blk_data_w-1:0]  scr_data;
    logic                   scr_bit;

    // 64 serial steps unrolled, lsb goes out first
    always_comb begin
        state_next = scr_state;
        for (int i = 0; i < blk_data_w; i++) begin
            scr_bit     = enc_data[i] ^ state_next[scr_tap_0] ^ state_next[scr_tap_1];
            scr_data[i] = scr_bit;
            state_next  = {state_next[scr_state_w-2:0], scr_bit};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scr_state <= '1;
            tx_data   <= '0;
            tx_hdr    <= sync_ctrl;
        end else begin
            scr_state <= state_next;  // keeps running in bypass too
            tx_data   <= scr_bypass ? enc_data : scr_data;
            tx_hdr    <= enc_hdr;     // header is never scrambled
        end
    end

endmodule

// ==== verilog/baser_tx_status.sv ====
// TX status block: APB registers with block and bad-block counters and scrambler bypass
`timescale 1ns/1ps

module baser_tx_status (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 enc_bad,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [baser_regs_pkg::apb_addr_w-1:0] paddr,
    input  logic [baser_regs_pkg::apb_data_w-1:0] pwdata,
    output logic [baser_regs_pkg::apb_data_w-1:0] prdata,
    output logic                                 pslverr,
    output logic                                 scr_bypass
);
    import baser_regs_pkg::*;

    logic [block_cnt_w-1:0] block_cnt;
    logic [bad_cnt_w-1:0]   bad_cnt;
    logic [apb_data_w-1:0]  rd_data;
    logic                   addr_hit;
    logic                   wr_en;
    logic                   cnt_clear;

    assign wr_en     = psel && penable && pwrite;  // access phase only
    assign cnt_clear = wr_en && paddr == reg_ctrl && pwdata[bit_cnt_clear];
    assign pslverr   = psel && penable && !addr_hit;

    // read mux and address decode
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (paddr)
            reg_ctrl:      rd_data[bit_scr_bypass] = scr_bypass;
            reg_block_cnt: rd_data = block_cnt;
            reg_bad_cnt:   rd_data = {{(apb_data_w-bad_cnt_w){1'b0}}, bad_cnt};
            default:       addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scr_bypass <= ctrl_reset[bit_scr_bypass];
            block_cnt  <= '0;
            bad_cnt    <= '0;
        end else begin
            if (wr_en && paddr == reg_ctrl)
                scr_bypass <= pwdata[bit_scr_bypass];
            if (cnt_clear) begin
                block_cnt <= '0;
                bad_cnt   <= '0;
            end else begin
                block_cnt <= block_cnt + 1'b1;  // one block per cycle
                if (enc_bad && bad_cnt != '1)
                    bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

    // read data captured in the setup phase, held through access
    always_ff @(posedge clk) begin
        if (psel && !penable && !pwrite)
            prdata <= rd_data;
    end

    a_apb_enable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel
    ) else $error("apb: penable rose without psel");

endmodule

// ==== verilog/baser_tx_top.sv ====
// 10GBASE-R PCS transmit top: XGMII encoder, scrambler and APB status block
`timescale 1ns/1ps

module baser_tx_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // XGMII side
    input  logic [baser_pkg::blk_data_w-1:0]       xgmii_txd,
    input  logic [7:0]                           xgmii_txc,
    // line side, one 66-bit block per cycle
    output logic [baser_pkg::blk_data_w-1:0]       tx_data,
    output logic [1:0]                           tx_hdr,
    // APB
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [baser_regs_pkg::apb_addr_w-1:0] paddr,
    input  logic [baser_regs_pkg::apb_data_w-1:0] pwdata,
    output logic [baser_regs_pkg::apb_data_w-1:0] prdata,
    output logic                                 pslverr
);
    import baser_pkg::*;

    logic [blk_data_w-1:0] enc_data;
    logic [1:0]            enc_hdr;
    logic                  enc_bad;
    logic                  scr_bypass;

    xgmii_baser_encoder i_xgmii_baser_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc),
        .enc_data  (enc_data),
        .enc_hdr   (enc_hdr),
        .enc_bad   (enc_bad)
    );

    baser_scrambler i_baser_scrambler (
        .clk        (clk),
        .rst_n      (rst_n),
        .scr_bypass (scr_bypass),
        .enc_data   (enc_data),
        .enc_hdr    (enc_hdr),
        .tx_data    (tx_data),
        .tx_hdr     (tx_hdr)
    );

    // sits beside the pipeline, watches the encoder
    baser_tx_status i_baser_tx_status (
        .clk        (clk),
        .rst_n      (rst_n),
        .enc_bad    (enc_bad),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .scr_bypass (scr_bypass)
    );

endmodule

// ==== verilog/xgmii_baser_encoder.sv ====
// XGMII encoder: maps one 64-bit XGMII word per cycle into a 66-bit 10GBASE-R block
`timescale 1ns/1ps

module xgmii_baser_encoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [baser_pkg::blk_data_w-1:0] xgmii_txd,
    input  logic [7:0]                     xgmii_txc,
    output logic [baser_pkg::blk_data_w-1:0] enc_data,
    output logic [1:0]                     enc_hdr,
    output logic                           enc_bad
);
    import baser_pkg::*;

    logic [55:0]           enc_ctrl;  // 7-bit code per lane
    logic [7:0]            enc_err;   // lane has no legal control code
    logic [blk_data_w-1:0] data_next;
    logic [1:0]            hdr_next;
    logic                  bad_next;

    // per-lane control code lookup
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            enc_err[i] = 1'b0;
            if (xgmii_txc[i]) begin
                case (xgmii_txd[8*i +: 8])
                    xgmii_idle:  enc_ctrl[7*i +: 7] = ctrl_idle;
                    xgmii_lpi:   enc_ctrl[7*i +: 7] = ctrl_lpi;
                    xgmii_error: enc_ctrl[7*i +: 7] = ctrl_error;
                    xgmii_res_0: enc_ctrl[7*i +: 7] = ctrl_res_0;
                    xgmii_res_1: enc_ctrl[7*i +: 7] = ctrl_res_1;
                    xgmii_res_2: enc_ctrl[7*i +: 7] = ctrl_res_2;
                    xgmii_res_3: enc_ctrl[7*i +: 7] = ctrl_res_3;
                    xgmii_res_4: enc_ctrl[7*i +: 7] = ctrl_res_4;
                    xgmii_res_5: enc_ctrl[7*i +: 7] = ctrl_res_5;
                    default: begin
                        enc_ctrl[7*i +: 7] = ctrl_error;  // unknown character
                        enc_err[i] = 1'b1;
                    end
                endcase
            end else begin
                // a data byte where a control code is needed
                enc_ctrl[7*i +: 7] = ctrl_error;
                enc_err[i] = 1'b1;
            end
        end
    end

    // block format selection
    always_comb begin
        bad_next = 1'b0;
        hdr_next = sync_ctrl;
        if (xgmii_txc == 8'h00) begin
            data_next = xgmii_txd;
            hdr_next  = sync_data;
        end else if (xgmii_txc == 8'h1f && xgmii_txd[39:32] == xgmii_seq_os) begin
            data_next = {xgmii_txd[63:40], o_seq_os, enc_ctrl[27:0], bt_os_4};
            bad_next  = |enc_err[3:0];
        end else if (xgmii_txc == 8'h1f && xgmii_txd[39:32] == xgmii_start) begin
            data_next = {xgmii_txd[63:40], 4'd0, enc_ctrl[27:0], bt_start_4};
            bad_next  = |enc_err[3:0];
        end else if (xgmii_txc == 8'h11 && xgmii_txd[7:0] == xgmii_seq_os
                     && xgmii_txd[39:32] == xgmii_start) begin
            data_next = {xgmii_txd[63:40], 4'd0, o_seq_os, xgmii_txd[31:8], bt_os_start};
        end else if (xgmii_txc == 8'h11 && xgmii_txd[7:0] == xgmii_seq_os
                     && xgmii_txd[39:32] == xgmii_seq_os) begin
            data_next = {xgmii_txd[63:40], o_seq_os, o_seq_os, xgmii_txd[31:8], bt_os_04};
        end else if (xgmii_txc == 8'h01 && xgmii_txd[7:0] == xgmii_start) begin
            data_next = {xgmii_txd[63:8], bt_start_0};
        end else if (xgmii_txc == 8'hf1 && xgmii_txd[7:0] == xgmii_seq_os) begin
            data_next = {enc_ctrl[55:28], o_seq_os, xgmii_txd[31:8], bt_os_0};
            bad_next  = |enc_err[7:4];
        end else if (xgmii_txc == 8'hff && xgmii_txd[7:0] == xgmii_term) begin
            data_next = {enc_ctrl[55:7], 7'd0, bt_term_0};
            bad_next  = |enc_err[7:1];
        end else if (xgmii_txc == 8'hfe && xgmii_txd[15:8] == xgmii_term) begin
            data_next = {enc_ctrl[55:14], 6'd0, xgmii_txd[7:0], bt_term_1};
            bad_next  = |enc_err[7:2];
        end else if (xgmii_txc == 8'hfc && xgmii_txd[23:16] == xgmii_term) begin
            data_next = {enc_ctrl[55:21], 5'd0, xgmii_txd[15:0], bt_term_2};
            bad_next  = |enc_err[7:3];
        end else if (xgmii_txc == 8'hf8 && xgmii_txd[31:24] == xgmii_term) begin
            data_next = {enc_ctrl[55:28], 4'd0, xgmii_txd[23:0], bt_term_3};
            bad_next  = |enc_err[7:4];
        end else if (xgmii_txc == 8'hf0 && xgmii_txd[39:32] == xgmii_term) begin
            data_next = {enc_ctrl[55:35], 3'd0, xgmii_txd[31:0], bt_term_4};
            bad_next  = |enc_err[7:5];
        end else if (xgmii_txc == 8'he0 && xgmii_txd[47:40] == xgmii_term) begin
            data_next = {enc_ctrl[55:42], 2'd0, xgmii_txd[39:0], bt_term_5};
            bad_next  = |enc_err[7:6];
        end else if (xgmii_txc == 8'hc0 && xgmii_txd[55:48] == xgmii_term) begin
            data_next = {enc_ctrl[55:49], 1'd0, xgmii_txd[47:0], bt_term_6};
            bad_next  = enc_err[7];
        end else if (xgmii_txc == 8'h80 && xgmii_txd[63:56] == xgmii_term) begin
            data_next = {xgmii_txd[55:0], bt_term_7};
        end else if (xgmii_txc == 8'hff) begin
            data_next = {enc_ctrl, bt_ctrl};  // idle, lpi, error or reserved codes
            bad_next  = |enc_err;
        end else begin
            // lane pattern fits no block format
            data_next = {{8{ctrl_error}}, bt_ctrl};
            bad_next  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enc_data <= '0;
            enc_hdr  <= sync_ctrl;
            enc_bad  <= 1'b0;
        end else begin
            enc_data <= data_next;
            enc_hdr  <= hdr_next;
            enc_bad  <= bad_next;  // same cycle as the block it flags
        end
    end

    // the sync header must always carry a transition
    a_hdr_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        enc_hdr == sync_data || enc_hdr == sync_ctrl
    ) else $error("encoder: illegal sync header %b", enc_hdr);

endmodule
